// ==== design/cp0_pkg.sv ====
package cp0_pkg;

	//////////////////////////////////////////////////////////////////////
	// Register addresses, select 0 only
	//////////////////////////////////////////////////////////////////////
	localparam logic [4:0] CP0_COUNT   = 5'd9;
	localparam logic [4:0] CP0_COMPARE = 5'd11;
	localparam logic [4:0] CP0_STATUS  = 5'd12;
	localparam logic [4:0] CP0_CAUSE   = 5'd13;
	localparam logic [4:0] CP0_EPC     = 5'd14;

	// Opcode and format fields
	localparam logic [5:0] OP_COP0    = 6'b010000;
	localparam logic [4:0] RS_MF      = 5'b00000;
	localparam logic [4:0] RS_MT      = 5'b00100;
	localparam logic [5:0] FUNCT_ERET = 6'h18;

	// Status fields
	localparam int ST_IE    = 0;
	localparam int ST_EXL   = 1;
	localparam int ST_IM_LO = 8;
	localparam int ST_IM_HI = 15;

	// Only IE, EXL and IM survive an mtc0
	localparam logic [31:0] STATUS_WR_MASK = 32'h0000_ff03;

	// Cause fields
	localparam int CA_BD     = 31;
	localparam int CA_IP_LO  = 8;
	localparam int CA_IP_HI  = 15;
	localparam int CA_EXC_LO = 2;
	localparam int CA_EXC_HI = 6;

	// Exception codes
	localparam logic [4:0] EXC_INT = 5'd0;
	localparam logic [4:0] EXC_SYS = 5'd8;
	localparam logic [4:0] EXC_BP  = 5'd9;
	localparam logic [4:0] EXC_RI  = 5'd10;
	localparam logic [4:0] EXC_OV  = 5'd12;

	//////////////////////////////////////////////////////////////////////
	// COP0 word, move format or CO format
	//////////////////////////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [7:0] zero;
			logic [2:0] sel;
		} move;
		struct packed {
			logic [5:0]  opcode;
			logic        co;
			logic [18:0] zero;
			logic [5:0]  funct;
		} co_op;
	} cp0_instr_u;

endpackage

// ==== design/cp0_decode.sv ====
`timescale 1ns/1ps

module cp0_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  cp0_pkg::cp0_instr_u instr,
	input  logic [31:0]         gpr_rdata,
	output logic                wr_en,
	output logic [4:0]          wr_addr,
	output logic [31:0]         wr_data,
	output logic                rd_en,
	output logic [4:0]          rd_addr,
	output logic [4:0]          rd_dest_d,
	output logic                eret
);
	import cp0_pkg::*;

	logic is_cop0;
	logic is_mt;
	logic is_mf;
	logic is_eret;

	// Opcode sits in the same bits for both formats
	assign is_cop0 = instr_valid && (instr.move.opcode == OP_COP0);

	// Move format, rs picks direction
	assign is_mt = is_cop0 && (instr.move.rs == RS_MT);
	assign is_mf = is_cop0 && (instr.move.rs == RS_MF);

	// CO format needs the co bit, which keeps it apart from MF/MT
	assign is_eret = is_cop0 && instr.co_op.co && (instr.co_op.funct == FUNCT_ERET);

	//////////////////////////////////////////////////////////////////////
	// Decode stage register
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
			rd_en <= 1'b0;
			eret  <= 1'b0;
		end else begin
			wr_en <= is_mt;
			rd_en <= is_mf;
			eret  <= is_eret;
		end
	end

	// Address and data ride along, qualified by the strobes
	always_ff @(posedge clk) begin
		wr_addr   <= instr.move.rd;
		wr_data   <= gpr_rdata;
		rd_addr   <= instr.move.rd;
		rd_dest_d <= instr.move.rt;
	end

	// At most one operation leaves decode per cycle
	a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({wr_en, rd_en, eret}));

endmodule

// ==== design/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wr_en,
	input  logic [4:0]  wr_addr,
	input  logic [31:0] wr_data,
	input  logic        eret,
	input  logic        exc_valid,
	input  logic [4:0]  exc_code,
	input  logic [31:0] exc_pc,
	input  logic        exc_bd,
	input  logic [4:0]  hw_int,
	output logic [31:0] count,
	output logic [31:0] compare,
	output logic [31:0] status,
	output logic [31:0] cause,
	output logic [31:0] epc,
	output logic        exc_taken,
	output logic        eret_taken
);
	import cp0_pkg::*;

	logic wr_count;
	logic wr_compare;
	logic wr_status;
	logic wr_cause;
	logic wr_epc;
	logic timer_hit;

	// Per-register write enables
	assign wr_count   = wr_en && (wr_addr == CP0_COUNT);
	assign wr_compare = wr_en && (wr_addr == CP0_COMPARE);
	assign wr_status  = wr_en && (wr_addr == CP0_STATUS);
	assign wr_cause   = wr_en && (wr_addr == CP0_CAUSE);
	assign wr_epc     = wr_en && (wr_addr == CP0_EPC);

	assign timer_hit = (count == compare);

	//////////////////////////////////////////////////////////////////////
	// Count and Compare
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (wr_count) begin
			count <= wr_data;
		end else begin
			count <= count + 32'd1;
		end
	end

	// All ones so the timer stays quiet out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			compare <= '1;
		end else if (wr_compare) begin
			compare <= wr_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Status
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			status <= '0;
		end else begin
			if (wr_status) begin
				status <= wr_data & STATUS_WR_MASK;
			end
			// eret leaves exception level
			if (eret) begin
				status[ST_EXL] <= 1'b0;
			end
			// Exception entry wins over a same-edge write
			if (exc_valid) begin
				status[ST_EXL] <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Cause
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cause <= '0;
		end else begin
			// IP7, Compare write clears before a match can set
			if (wr_compare) begin
				cause[CA_IP_HI] <= 1'b0;
			end else if (timer_hit) begin
				cause[CA_IP_HI] <= 1'b1;
			end
			// IP6..IP2 follow the hardware lines
			cause[CA_IP_HI-1:CA_IP_LO+2] <= hw_int;
			// Software bits only
			if (wr_cause) begin
				cause[CA_IP_LO+1:CA_IP_LO] <= wr_data[CA_IP_LO+1:CA_IP_LO];
			end
			if (exc_valid) begin
				cause[CA_BD]                <= exc_bd;
				cause[CA_EXC_HI:CA_EXC_LO]  <= exc_code;
			end
		end
	end

	// EPC keeps the first fault pc when already at exception level
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			epc <= '0;
		end else if (exc_valid && !status[ST_EXL]) begin
			epc <= exc_pc;
		end else if (wr_epc) begin
			epc <= wr_data;
		end
	end

	// Taken pulses for the result stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exc_taken  <= 1'b0;
			eret_taken <= 1'b0;
		end else begin
			exc_taken  <= exc_valid;
			eret_taken <= eret;
		end
	end

	// Pipeline never raises an exception under an executing eret
	a_no_exc_eret: assert property (@(posedge clk) disable iff (!rst_n)
		!(exc_valid && eret));

	// Taken pulse only ever seen at exception level
	a_exc_exl: assert property (@(posedge clk) disable iff (!rst_n)
		exc_taken |-> status[ST_EXL]);

endmodule

// ==== design/cp0_result.sv ====
`timescale 1ns/1ps

module cp0_result #(
	parameter logic [31:0] EXC_VECTOR = 32'h8000_0180
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rd_en,
	input  logic [4:0]  rd_addr,
	input  logic [4:0]  rd_dest_d,
	input  logic [31:0] count,
	input  logic [31:0] compare,
	input  logic [31:0] status,
	input  logic [31:0] cause,
	input  logic [31:0] epc,
	input  logic        exc_taken,
	input  logic        eret_taken,
	output logic        rd_valid,
	output logic [4:0]  rd_dest,
	output logic [31:0] rd_data,
	output logic        int_req,
	output logic        redirect_valid,
	output logic [31:0] redirect_pc
);
	import cp0_pkg::*;

	logic [31:0] rd_mux;
	logic [7:0]  ip_masked;

	// mfc0 source select, holes read zero
	always_comb begin
		case (rd_addr)
			CP0_COUNT:   rd_mux = count;
			CP0_COMPARE: rd_mux = compare;
			CP0_STATUS:  rd_mux = status;
			CP0_CAUSE:   rd_mux = cause;
			CP0_EPC:     rd_mux = epc;
			default:     rd_mux = '0;
		endcase
	end

	// Result register, one cycle of valid per read
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
			rd_dest  <= '0;
			rd_data  <= '0;
		end else begin
			rd_valid <= rd_en;
			rd_dest  <= rd_dest_d;
			rd_data  <= rd_mux;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Interrupt request and redirect
	//////////////////////////////////////////////////////////////////////
	assign ip_masked = cause[CA_IP_HI:CA_IP_LO] & status[ST_IM_HI:ST_IM_LO];
	assign int_req   = status[ST_IE] && !status[ST_EXL] && (|ip_masked);

	// Vector on exception, EPC on eret
	assign redirect_valid = exc_taken || eret_taken;
	assign redirect_pc    = exc_taken ? EXC_VECTOR : epc;

	// Only one redirect source per cycle
	a_one_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		!(exc_taken && eret_taken));

endmodule

// ==== design/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top #(
	parameter logic [31:0] EXC_VECTOR = 32'h8000_0180
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  logic [31:0] instr,
	input  logic [31:0] gpr_rdata,
	input  logic        exc_valid,
	input  logic [4:0]  exc_code,
	input  logic [31:0] exc_pc,
	input  logic        exc_bd,
	input  logic [4:0]  hw_int,
	output logic        rd_valid,
	output logic [4:0]  rd_dest,
	output logic [31:0] rd_data,
	output logic        int_req,
	output logic        redirect_valid,
	output logic [31:0] redirect_pc
);

	// Decode to execute
	logic        wr_en;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;
	logic        eret;

	// Decode to result
	logic        rd_en;
	logic [4:0]  rd_addr;
	logic [4:0]  rd_dest_d;

	// Register file to result
	logic [31:0] count;
	logic [31:0] compare;
	logic [31:0] status;
	logic [31:0] cause;
	logic [31:0] epc;
	logic        exc_taken;
	logic        eret_taken;

	//////////////////////////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////////////////////////
	cp0_decode i_decode (
		.clk, .rst_n, .instr_valid, .instr, .gpr_rdata,
		.wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_dest_d, .eret
	);

	cp0_regs i_regs (
		.clk, .rst_n, .wr_en, .wr_addr, .wr_data, .eret,
		.exc_valid, .exc_code, .exc_pc, .exc_bd, .hw_int,
		.count, .compare, .status, .cause, .epc, .exc_taken, .eret_taken
	);

	// Redirect vector set here
	cp0_result #(
		.EXC_VECTOR(EXC_VECTOR)
	) i_result (
		.clk, .rst_n, .rd_en, .rd_addr, .rd_dest_d,
		.count, .compare, .status, .cause, .epc, .exc_taken, .eret_taken,
		.rd_valid, .rd_dest, .rd_data, .int_req, .redirect_valid, .redirect_pc
	);

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset low for 16 rising edges, released just after the last one
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// ==== dv/cp0_model.svh ====
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model of decode stage and CP0 registers
//////////////////////////////////////////////////////////////////////
typedef struct {
	logic [4:0]  dest;
	logic [31:0] data;
	int          due;
} read_exp_t;

typedef struct {
	logic [31:0] pc;
	int          due;
} redirect_exp_t;

// IE, EXL and IM
localparam logic [31:0] ST_KEEP = 32'h0000_ff03;

read_exp_t     read_q[$];
redirect_exp_t redirect_q[$];
int            edge_n = 0;

// Word held in decode
logic        m_wr = 1'b0;
logic        m_rd = 1'b0;
logic        m_eret = 1'b0;
logic [4:0]  m_addr = '0;
logic [31:0] m_data = '0;
logic [4:0]  m_dest = '0;

// Register values after the last edge
logic [31:0] m_count = '0;
logic [31:0] m_compare = '1;
logic [31:0] m_status = '0;
logic [31:0] m_cause = '0;
logic [31:0] m_epc = '0;

function automatic logic [31:0] model_reg(input logic [4:0] addr);
	case (addr)
		CP0_COUNT:   return m_count;
		CP0_COMPARE: return m_compare;
		CP0_STATUS:  return m_status;
		CP0_CAUSE:   return m_cause;
		CP0_EPC:     return m_epc;
		default:     return 32'd0;
	endcase
endfunction

function automatic logic model_int();
	return m_status[ST_IE] && !m_status[ST_EXL] && (|(m_cause[15:8] & m_status[15:8]));
endfunction

// One rising edge of the whole CP0
task automatic model_step();
	read_exp_t     re;
	redirect_exp_t rr;
	cp0_instr_u    w;
	logic          hit;
	logic          old_exl;
	edge_n++;
	hit     = (m_count == m_compare);
	old_exl = m_status[ST_EXL];
	// mfc0 in execute sees registers from before this edge
	if (m_rd) begin
		re.dest = m_dest;
		re.data = model_reg(m_addr);
		re.due  = edge_n;
		read_q.push_back(re);
	end
	if (m_wr && m_addr == CP0_COUNT) m_count = m_data;
	else m_count = m_count + 32'd1;
	if (m_wr && m_addr == CP0_COMPARE) m_compare = m_data;
	// Status masked write, then eret, then exception entry
	if (m_wr && m_addr == CP0_STATUS) m_status = m_data & ST_KEEP;
	if (m_eret) m_status[ST_EXL] = 1'b0;
	if (exc_valid) m_status[ST_EXL] = 1'b1;
	// Timer bit
	if (m_wr && m_addr == CP0_COMPARE) m_cause[CA_IP_HI] = 1'b0;
	else if (hit) m_cause[CA_IP_HI] = 1'b1;
	m_cause[CA_IP_HI-1:CA_IP_LO+2] = hw_int;
	if (m_wr && m_addr == CP0_CAUSE) m_cause[CA_IP_LO+1:CA_IP_LO] = m_data[CA_IP_LO+1:CA_IP_LO];
	if (exc_valid) begin
		m_cause[CA_BD]               = exc_bd;
		m_cause[CA_EXC_HI:CA_EXC_LO] = exc_code;
	end
	// First fault pc kept while at exception level
	if (exc_valid && !old_exl) m_epc = exc_pc;
	else if (m_wr && m_addr == CP0_EPC) m_epc = m_data;
	// Redirects show up in the cycle after this edge
	rr.due = edge_n;
	if (exc_valid) begin
		rr.pc = EXC_VEC;
		redirect_q.push_back(rr);
	end
	if (m_eret) begin
		rr.pc = m_epc;
		redirect_q.push_back(rr);
	end
	// Capture the next word into decode
	w      = instr;
	m_wr   = 1'b0;
	m_rd   = 1'b0;
	m_eret = 1'b0;
	if (instr_valid && w.move.opcode == OP_COP0) begin
		m_wr   = (w.move.rs == RS_MT);
		m_rd   = (w.move.rs == RS_MF);
		m_eret = w.co_op.co && (w.co_op.funct == FUNCT_ERET);
	end
	m_addr = w.move.rd;
	m_data = gpr_rdata;
	m_dest = w.move.rt;
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////
task automatic check_read(input logic [4:0] dest, input logic [31:0] data);
	read_exp_t e;
	if (read_q.size() == 0)
		fail_run($sformatf("error at %0t: read to r%0d with no mfc0 in flight", $time, dest));
	e = read_q.pop_front();
	if (e.due != edge_n)
		fail_run($sformatf("error at %0t: read at edge %0d, expected edge %0d",
			$time, edge_n, e.due));
	if (dest !== e.dest || data !== e.data)
		fail_run($sformatf("error at %0t: read r%0d = %h, expected r%0d = %h",
			$time, dest, data, e.dest, e.data));
endtask

task automatic check_redirect(input logic [31:0] pc);
	redirect_exp_t e;
	if (redirect_q.size() == 0)
		fail_run($sformatf("error at %0t: redirect to %h not expected", $time, pc));
	e = redirect_q.pop_front();
	if (e.due != edge_n || pc !== e.pc)
		fail_run($sformatf("error at %0t: redirect %h at edge %0d, expected %h at edge %0d",
			$time, pc, edge_n, e.pc, e.due));
endtask

task automatic check_int(input logic level);
	if (level !== model_int())
		fail_run($sformatf("error at %0t: int_req %b, expected %b", $time, level, model_int()));
endtask

// Bounded wait on every result still owed
task automatic check_pending();
	if (read_q.size() != 0 && edge_n - read_q[0].due > WAIT_LIMIT)
		fail_run("Timed out: an mfc0 result did not arrive within 10 cycles");
	if (redirect_q.size() != 0 && edge_n - redirect_q[0].due > WAIT_LIMIT)
		fail_run("Timed out: a redirect did not arrive within 10 cycles");
endtask

`endif

// ==== dv/tb_cp0.sv ====
`timescale 1ns/1ps

module tb_cp0;
	import cp0_pkg::*;

	localparam logic [31:0] EXC_VEC    = 32'hbfc0_0380;
	localparam int          NUM_CYCLES = 3000;
	localparam int          WAIT_LIMIT = 10;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] gpr_rdata;
	logic        exc_valid;
	logic [4:0]  exc_code;
	logic [31:0] exc_pc;
	logic        exc_bd;
	logic [4:0]  hw_int;
	logic        rd_valid;
	logic [4:0]  rd_dest;
	logic [31:0] rd_data;
	logic        int_req;
	logic        redirect_valid;
	logic [31:0] redirect_pc;

	logic [4:0] exc_codes [5] = '{EXC_INT, EXC_SYS, EXC_BP, EXC_RI, EXC_OV};
	int         guard;

	tb_clock i_clock (
		.clk,
		.rst_n
	);

	cp0_top #(
		.EXC_VECTOR(EXC_VEC)
	) i_dut (
		.clk, .rst_n, .instr_valid, .instr, .gpr_rdata,
		.exc_valid, .exc_code, .exc_pc, .exc_bd, .hw_int,
		.rd_valid, .rd_dest, .rd_data, .int_req, .redirect_valid, .redirect_pc
	);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	`include "cp0_model.svh"

	// Mostly implemented registers, now and then any address
	function automatic logic [4:0] pick_reg();
		case ($urandom % 7)
			0: return CP0_COUNT;
			1: return CP0_COMPARE;
			2: return CP0_STATUS;
			3: return CP0_CAUSE;
			4: return CP0_EPC;
			default: return 5'($urandom);
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Random stimulus, one word per cycle
	//////////////////////////////////////////////////////////////////////
	task automatic drive_inputs();
		cp0_instr_u  w;
		int unsigned kind;
		w           = $urandom;
		kind        = $urandom % 100;
		gpr_rdata   = $urandom;
		instr_valid = (kind < 85);
		if (kind < 60) begin
			// mtc0 below 30, mfc0 above
			w             = '0;
			w.move.opcode = OP_COP0;
			w.move.rs     = (kind < 30) ? RS_MT : RS_MF;
			w.move.rt     = 5'($urandom);
			w.move.rd     = pick_reg();
			// Compare just ahead of Count so the timer fires
			if (w.move.rd == CP0_COMPARE) gpr_rdata = m_count + ($urandom % 24);
			if (w.move.rd == CP0_COUNT) gpr_rdata = $urandom % 64;
		end else if (kind < 66) begin
			w              = '0;
			w.co_op.opcode = OP_COP0;
			w.co_op.co     = 1'b1;
			w.co_op.funct  = FUNCT_ERET;
		end else if (kind < 85) begin
			// Junk with any opcode but COP0
			w.move.opcode = 6'($urandom % 16);
		end
		instr = w;
		// No exception while an eret moves into execute
		exc_valid = ($urandom % 25 == 0) && !m_eret;
		exc_code  = exc_codes[3'($urandom % 5)];
		exc_pc    = $urandom & 32'hffff_fffc;
		exc_bd    = 1'($urandom);
		if ($urandom % 8 == 0) hw_int = 5'($urandom);
	endtask

	task automatic observe_outputs();
		if (rd_valid === 1'b1) check_read(rd_dest, rd_data);
		if (redirect_valid === 1'b1) check_redirect(redirect_pc);
		check_int(int_req);
		check_pending();
	endtask

	function automatic logic results_owed();
		return read_q.size() != 0 || redirect_q.size() != 0 || m_rd || m_eret;
	endfunction

	initial begin
		void'($urandom(45));
		instr_valid = 1'b0;
		instr       = '0;
		gpr_rdata   = '0;
		exc_valid   = 1'b0;
		exc_code    = '0;
		exc_pc      = '0;
		exc_bd      = 1'b0;
		hw_int      = '0;
		guard       = 0;
		while (rst_n !== 1'b1) begin
			if (guard == 40) fail_run("Timed out waiting for reset to be released");
			@(posedge clk);
			#3;
			guard++;
		end
		// Quiet outputs straight out of reset
		if (rd_valid !== 1'b0 || redirect_valid !== 1'b0 || int_req !== 1'b0)
			fail_run($sformatf("error at %0t: outputs not low after reset", $time));

		// Sample 1 ns after the edge, drive 2 ns after it
		repeat (NUM_CYCLES) begin
			@(posedge clk);
			model_step();
			#1;
			observe_outputs();
			#1;
			drive_inputs();
		end

		// Let the last instructions drain
		instr_valid = 1'b0;
		exc_valid   = 1'b0;
		guard       = 0;
		do begin
			if (guard == WAIT_LIMIT) fail_run("Timed out: results still owed after the last word");
			@(posedge clk);
			model_step();
			#1;
			observe_outputs();
			guard++;
		end while (results_owed());

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+dv
design/cp0_pkg.sv
design/cp0_decode.sv
design/cp0_regs.sv
design/cp0_result.sv
design/cp0_top.sv
dv/tb_clock.sv
dv/tb_cp0.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_cp0 \
	-f compile.f -o sim_cp0 > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_cp0 > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Run ended without a verdict"; exit 1; }
exit 0
